// File: vna_dsp.f
hw/vna_dsp_params_pkg.sv
hw/vna_dsp_types_pkg.sv
hw/iq_stream_if.sv
hw/frame_sequencer.sv
hw/rx_channel_filter.sv
hw/frame_averager.sv
hw/vna_dsp.sv
verif/vna_dsp_checker.sv
verif/vna_dsp_tb.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run the vna_dsp testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing -j 0 \
    --top-module vna_dsp_tb \
    -f vna_dsp.f \
    --Mdir "$OBJ" -o vna_dsp_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"$OBJ/vna_dsp_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

# The log decides the result
if grep -q "TESTS FAILED" "$LOG"; then
    exit 1
fi
exit 0

// File: verif/vna_dsp_tb.sv
`timescale 1ns/1ps

module vna_dsp_tb;

    typedef enum logic [1:0] {
        MODE_CONST,
        MODE_LFSR,
        MODE_FULL
    } mode_e;

    // One row per test
    typedef struct packed {
        logic [3:0]  log2;
        mode_e       mode;
        logic [31:0] cval;
        logic [3:0]  gap;     // Idle cycles before each sample
        logic        extra;   // Idle samples, start while running, sample in start cycle
        logic [3:0]  frames;
        logic [3:0]  pulses;  // Expected count of averaged frames
    } row_t;

    logic aclk = 1'b0;
    logic rst_n;
    logic start;
    logic [vna_dsp_params_pkg::LOG2_W-1:0] frame_log2;
    logic adc_valid;
    logic [vna_dsp_params_pkg::NUM_CH-1:0][vna_dsp_params_pkg::ADC_W-1:0] adc_data;
    logic busy;
    logic avg_valid;
    vna_dsp_types_pkg::sample_t [vna_dsp_params_pkg::NUM_CH-1:0] avg_i;
    vna_dsp_types_pkg::sample_t [vna_dsp_params_pkg::NUM_CH-1:0] avg_q;
    logic test_end;
    int   exp_pulses;
    int   chk_pending;
    int   chk_test_pulses;
    int   chk_test_errs;
    int   chk_err_total;
    int   chk_checks;
    int   failed_tests;
    logic table_ready = 1'b0;
    logic [31:0] lfsr_state;
    row_t  rows  [10];
    string names [10];

    always #2 aclk = ~aclk;  // 4 ns period

    vna_dsp vna_dsp_inst (
        .aclk       (aclk),
        .rst_n      (rst_n),
        .start      (start),
        .frame_log2 (frame_log2),
        .adc_valid  (adc_valid),
        .adc_data   (adc_data),
        .busy       (busy),
        .avg_valid  (avg_valid),
        .avg_i      (avg_i),
        .avg_q      (avg_q)
    );

    vna_dsp_checker vna_dsp_checker_inst (
        .aclk        (aclk),
        .rst_n       (rst_n),
        .start       (start),
        .frame_log2  (frame_log2),
        .adc_valid   (adc_valid),
        .adc_data    (adc_data),
        .busy        (busy),
        .avg_valid   (avg_valid),
        .avg_i       (avg_i),
        .avg_q       (avg_q),
        .test_end    (test_end),
        .exp_pulses  (exp_pulses),
        .pending     (chk_pending),
        .test_pulses (chk_test_pulses),
        .test_errs   (chk_test_errs),
        .err_total   (chk_err_total),
        .check_total (chk_checks)
    );

    task automatic load_table();
        names[0] = "const_16";
        rows[0]  = '{4'd4,  MODE_CONST, 32'h1234_e000, 4'd0, 1'b0, 4'd2, 4'd2};
        names[1] = "rand_log0";
        rows[1]  = '{4'd0,  MODE_LFSR,  32'h0, 4'd0, 1'b0, 4'd3, 4'd3};
        names[2] = "rand_log4";
        rows[2]  = '{4'd4,  MODE_LFSR,  32'h0, 4'd0, 1'b0, 4'd1, 4'd1};
        names[3] = "rand_log8";
        rows[3]  = '{4'd8,  MODE_LFSR,  32'h0, 4'd0, 1'b0, 4'd1, 4'd1};
        names[4] = "clamp_log12";
        rows[4]  = '{4'd12, MODE_LFSR,  32'h0, 4'd0, 1'b0, 4'd1, 4'd1};
        names[5] = "valid_gaps";
        rows[5]  = '{4'd4,  MODE_LFSR,  32'h0, 4'd3, 1'b0, 4'd1, 4'd1};
        names[6] = "gating";
        rows[6]  = '{4'd5,  MODE_LFSR,  32'h0, 4'd1, 1'b1, 4'd1, 4'd1};
        names[7] = "full_scale";
        rows[7]  = '{4'd4,  MODE_FULL,  32'h0, 4'd0, 1'b0, 4'd2, 4'd2};
        names[8] = "full_const";
        rows[8]  = '{4'd3,  MODE_CONST, 32'h7fff_8000, 4'd0, 1'b0, 4'd1, 4'd1};
        names[9] = "back_to_back";
        rows[9]  = '{4'd2,  MODE_LFSR,  32'h0, 4'd0, 1'b0, 4'd4, 4'd4};
    endtask

    // Galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [31:0] rand_word();
        logic [31:0] w;
        w = '0;
        for (int b = 0; b < 32; b++) begin
            w          = {w[30:0], lfsr_state[0]};
            lfsr_state = lfsr_step(lfsr_state);
        end
        return w;
    endfunction

    function automatic int frame_len(input logic [3:0] log2);
        return 1 << ((int'(log2) > vna_dsp_params_pkg::MAX_FRAME_LOG2) ?
                     vna_dsp_params_pkg::MAX_FRAME_LOG2 : int'(log2));
    endfunction

    task automatic next_cycle();
        @(posedge aclk);
        #1;
    endtask

    task automatic drive_word(input row_t r, input int n);
        for (int k = 0; k < vna_dsp_params_pkg::NUM_CH; k++) begin
            case (r.mode)
                MODE_CONST: adc_data[k] = r.cval;
                MODE_LFSR:  adc_data[k] = rand_word();  // Own draw per channel
                default:    adc_data[k] = (k == 3) ? 32'h8000_8000 :
                                          (((n + k) % 2) != 0) ? 32'h8000_7fff : 32'h7fff_8000;
            endcase
        end
    endtask

    task automatic run_row(input int idx);
        row_t r;
        int   len;
        r   = rows[idx];
        len = frame_len(r.log2);
        if (r.extra) begin
            repeat (2) begin
                next_cycle();
                adc_valid = 1'b1;  // Sequencer still idle
                drive_word(r, 0);
            end
        end
        for (int f = 0; f < int'(r.frames); f++) begin
            next_cycle();
            start      = 1'b1;
            frame_log2 = r.log2;
            adc_valid  = r.extra;
            drive_word(r, 0);
            for (int s = 0; s < len; s++) begin
                repeat (int'(r.gap)) begin
                    next_cycle();
                    start     = 1'b0;
                    adc_valid = 1'b0;
                end
                next_cycle();
                start     = r.extra && (s == len / 2);  // Ignored mid frame
                adc_valid = 1'b1;
                drive_word(r, s);
            end
        end
        next_cycle();
        start     = 1'b0;
        adc_valid = 1'b0;
        while (busy || chk_pending != 0) begin
            next_cycle();
        end
        test_end   = 1'b1;
        exp_pulses = int'(r.pulses);
        next_cycle();
        test_end = 1'b0;
        if (chk_test_errs != 0) begin
            failed_tests++;
        end
        $display("%s: %0d averaged frames, %0d errors, %s", names[idx], chk_test_pulses,
                 chk_test_errs, (chk_test_errs == 0) ? "ok" : "failed");
    endtask

    initial begin : watchdog
        int frame_cycles;
        int max_gap;
        wait (table_ready);
        frame_cycles = 0;
        max_gap      = 0;
        for (int r = 0; r < $size(rows); r++) begin
            frame_cycles += int'(rows[r].frames) * frame_len(rows[r].log2);
            if (int'(rows[r].gap) > max_gap) begin
                max_gap = int'(rows[r].gap);
            end
        end
        #(frame_cycles * (max_gap + 1) * 4 + 2000);
        $display("Timeout: the tests did not finish in the expected time");
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        rst_n        = 1'b0;
        start        = 1'b0;
        frame_log2   = '0;
        adc_valid    = 1'b0;
        adc_data     = '0;
        test_end     = 1'b0;
        exp_pulses   = 0;
        failed_tests = 0;
        lfsr_state   = 32'h9591108a;
        load_table();
        table_ready = 1'b1;
        repeat (2) @(posedge aclk);
        #1;
        rst_n = 1'b1;
        for (int r = 0; r < $size(rows); r++) begin
            run_row(r);
        end
        $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors", $size(rows),
                 failed_tests, chk_checks, chk_err_total);
        if (failed_tests == 0 && chk_err_total == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: verif/vna_dsp_checker.sv
`timescale 1ns/1ps

// Reference model of gating, FIR and frame averaging checked on every falling edge
module vna_dsp_checker (
    input  logic                                                        aclk,
    input  logic                                                        rst_n,
    input  logic                                                        start,
    input  logic [vna_dsp_params_pkg::LOG2_W-1:0]                       frame_log2,
    input  logic                                                        adc_valid,
    input  logic [vna_dsp_params_pkg::NUM_CH-1:0]
                 [vna_dsp_params_pkg::ADC_W-1:0]                        adc_data,
    input  logic                                                        busy,
    input  logic                                                        avg_valid,
    input  vna_dsp_types_pkg::sample_t [vna_dsp_params_pkg::NUM_CH-1:0] avg_i,
    input  vna_dsp_types_pkg::sample_t [vna_dsp_params_pkg::NUM_CH-1:0] avg_q,
    input  logic                                                        test_end,
    input  int                                                          exp_pulses,
    output int                                                          pending,
    output int                                                          test_pulses,
    output int                                                          test_errs,
    output int                                                          err_total,
    output int                                                          check_total
);

    typedef logic [vna_dsp_params_pkg::NUM_CH-1:0][vna_dsp_params_pkg::SAMPLE_W-1:0] means_t;

    int     hist_i [vna_dsp_params_pkg::NUM_CH][vna_dsp_params_pkg::NUM_TAPS];
    int     hist_q [vna_dsp_params_pkg::NUM_CH][vna_dsp_params_pkg::NUM_TAPS];
    int     acc_i  [vna_dsp_params_pkg::NUM_CH];
    int     acc_q  [vna_dsp_params_pkg::NUM_CH];
    logic   run = 1'b0;
    int     shift = 0;
    int     count = 0;
    longint cyc = 0;
    int     errs = 0;
    int     checks = 0;
    int     cur_pulses = 0;
    int     cur_errs = 0;
    int     done_pulses = 0;
    int     done_errs = 0;
    int     n_pending = 0;
    longint due_q [$];  // Falling edge on which avg_valid is due
    means_t exp_i_q [$];
    means_t exp_q_q [$];

    assign pending     = n_pending;
    assign test_pulses = done_pulses;
    assign test_errs   = done_errs;
    assign err_total   = errs;
    assign check_total = checks;

    task automatic report_mismatch(input string msg);
        $display("[FAIL] %0t: %s", $time, msg);
        errs++;
        cur_errs++;
    endtask

    task automatic event_error(input string msg);
        $display("Error at time %0t: %s", $time, msg);
        errs++;
        cur_errs++;
    endtask

    // Taps times coefficients, scaled back and clipped to 16 bits
    function automatic int fir_result(input int k, input logic use_q);
        longint s;
        s = 0;
        for (int n = 0; n < vna_dsp_params_pkg::NUM_TAPS; n++) begin
            s += longint'(use_q ? hist_q[k][n] : hist_i[k][n]) *
                 longint'(vna_dsp_params_pkg::FIR_COEFS[n]);
        end
        s = s >>> vna_dsp_params_pkg::COEF_FRAC;
        if (s > 32767) begin
            s = 32767;
        end else if (s < -32768) begin
            s = -32768;
        end
        return int'(s);
    endfunction

    task automatic close_frame();
        means_t ei;
        means_t eq;
        for (int k = 0; k < vna_dsp_params_pkg::NUM_CH; k++) begin
            ei[k]    = vna_dsp_params_pkg::SAMPLE_W'(acc_i[k] >>> shift);
            eq[k]    = vna_dsp_params_pkg::SAMPLE_W'(acc_q[k] >>> shift);
            acc_i[k] = 0;
            acc_q[k] = 0;
        end
        due_q.push_back(cyc + 3);  // Three registers after the edge that takes the last sample
        exp_i_q.push_back(ei);
        exp_q_q.push_back(eq);
    endtask

    task automatic step_model();
        if (!run) begin
            if (start) begin
                run   = 1'b1;
                count = 0;
                shift = (int'(frame_log2) > vna_dsp_params_pkg::MAX_FRAME_LOG2) ?
                        vna_dsp_params_pkg::MAX_FRAME_LOG2 : int'(frame_log2);
            end
        end else if (adc_valid) begin
            count++;
            for (int k = 0; k < vna_dsp_params_pkg::NUM_CH; k++) begin
                for (int n = vna_dsp_params_pkg::NUM_TAPS - 1; n > 0; n--) begin
                    hist_i[k][n] = hist_i[k][n-1];
                    hist_q[k][n] = hist_q[k][n-1];
                end
                hist_i[k][0] = int'($signed(adc_data[k][31:16]));
                hist_q[k][0] = int'($signed(adc_data[k][15:0]));
                acc_i[k] += fir_result(k, 1'b0);
                acc_q[k] += fir_result(k, 1'b1);
            end
            if (count == (1 << shift)) begin
                close_frame();
                run = 1'b0;
            end
        end
    endtask

    task automatic compare_means(input means_t ei, input means_t eq);
        for (int k = 0; k < vna_dsp_params_pkg::NUM_CH; k++) begin
            checks++;
            if (avg_i[k] !== ei[k]) begin
                report_mismatch($sformatf("ch%0d I mean %0d, expected %0d", k, avg_i[k],
                                          $signed(ei[k])));
            end
            if (avg_q[k] !== eq[k]) begin
                report_mismatch($sformatf("ch%0d Q mean %0d, expected %0d", k, avg_q[k],
                                          $signed(eq[k])));
            end
        end
    endtask

    always @(negedge aclk) begin
        means_t ei;
        means_t eq;
        longint due;
        cyc++;
        checks++;
        if (!rst_n) begin
            if (busy !== 1'b0 || avg_valid !== 1'b0 || avg_i !== '0 || avg_q !== '0) begin
                report_mismatch("outputs not cleared during reset");
            end
            run = 1'b0;
            due_q.delete();
            exp_i_q.delete();
            exp_q_q.delete();
            for (int k = 0; k < vna_dsp_params_pkg::NUM_CH; k++) begin
                acc_i[k] = 0;
                acc_q[k] = 0;
                for (int n = 0; n < vna_dsp_params_pkg::NUM_TAPS; n++) begin
                    hist_i[k][n] = 0;
                    hist_q[k][n] = 0;
                end
            end
        end else begin
            if (busy !== run) begin
                report_mismatch($sformatf("busy is %b, expected %b", busy, run));
            end
            if (avg_valid === 1'b1) begin
                if (due_q.size() == 0) begin
                    event_error("avg_valid pulsed with no frame outstanding");
                end else begin
                    due = due_q.pop_front();
                    ei  = exp_i_q.pop_front();
                    eq  = exp_q_q.pop_front();
                    cur_pulses++;
                    if (due != cyc) begin
                        event_error($sformatf("avg_valid came %0d cycles early", due - cyc));
                    end
                    compare_means(ei, eq);
                end
            end else if (due_q.size() != 0 && due_q[0] <= cyc) begin
                event_error("no averaged result 3 cycles after the last sample of a frame");
                due = due_q.pop_front();
                ei  = exp_i_q.pop_front();
                eq  = exp_q_q.pop_front();
            end
            if (test_end) begin
                if (cur_pulses != exp_pulses) begin
                    report_mismatch($sformatf("%0d averaged frames, expected %0d", cur_pulses,
                                              exp_pulses));
                end
                done_pulses = cur_pulses;
                done_errs   = cur_errs;
                cur_pulses  = 0;
                cur_errs    = 0;
            end
            step_model();
        end
        n_pending = due_q.size();
    end

endmodule

// File: hw/vna_dsp.sv
`timescale 1ns/1ps

module vna_dsp (
    input  logic                                         aclk,
    input  logic                                         rst_n,
    input  logic                                         start,
    input  logic [vna_dsp_params_pkg::LOG2_W-1:0]        frame_log2,
    input  logic                                         adc_valid,
    // Channel order: p1 reverse, p1 forward, p2 reverse, p2 forward
    input  logic [vna_dsp_params_pkg::NUM_CH-1:0]
                 [vna_dsp_params_pkg::ADC_W-1:0]         adc_data,
    output logic                                         busy,
    output logic                                         avg_valid,
    output vna_dsp_types_pkg::sample_t [vna_dsp_params_pkg::NUM_CH-1:0] avg_i,
    output vna_dsp_types_pkg::sample_t [vna_dsp_params_pkg::NUM_CH-1:0] avg_q
);

    iq_stream_if seq_to_fir [vna_dsp_params_pkg::NUM_CH] (.aclk(aclk));
    iq_stream_if fir_to_avg [vna_dsp_params_pkg::NUM_CH] (.aclk(aclk));

    frame_sequencer frame_sequencer_inst (
        .aclk       (aclk),
        .rst_n      (rst_n),
        .start      (start),
        .frame_log2 (frame_log2),
        .adc_valid  (adc_valid),
        .adc_data   (adc_data),
        .busy       (busy),
        .out        (seq_to_fir)
    );

    // One filter per receiver channel
    for (genvar k = 0; k < vna_dsp_params_pkg::NUM_CH; k++) begin : g_rx
        rx_channel_filter rx_channel_filter_inst (
            .aclk  (aclk),
            .rst_n (rst_n),
            .in    (seq_to_fir[k]),
            .out   (fir_to_avg[k])
        );
    end

    frame_averager frame_averager_inst (
        .aclk      (aclk),
        .rst_n     (rst_n),
        .in        (fir_to_avg),
        .avg_valid (avg_valid),
        .avg_i     (avg_i),
        .avg_q     (avg_q)
    );

endmodule

// File: hw/frame_averager.sv
`timescale 1ns/1ps

module frame_averager (
    input  logic                                         aclk,
    input  logic                                         rst_n,
    iq_stream_if.dst                                     in [vna_dsp_params_pkg::NUM_CH],
    output logic                                         avg_valid,
    output vna_dsp_types_pkg::sample_t [vna_dsp_params_pkg::NUM_CH-1:0] avg_i,
    output vna_dsp_types_pkg::sample_t [vna_dsp_params_pkg::NUM_CH-1:0] avg_q
);

    vna_dsp_types_pkg::sample_t                 smp_i [vna_dsp_params_pkg::NUM_CH];
    vna_dsp_types_pkg::sample_t                 smp_q [vna_dsp_params_pkg::NUM_CH];
    logic signed [vna_dsp_params_pkg::ACC_W-1:0] acc_i [vna_dsp_params_pkg::NUM_CH];
    logic signed [vna_dsp_params_pkg::ACC_W-1:0] acc_q [vna_dsp_params_pkg::NUM_CH];
    logic signed [vna_dsp_params_pkg::ACC_W-1:0] sum_i [vna_dsp_params_pkg::NUM_CH];
    logic signed [vna_dsp_params_pkg::ACC_W-1:0] sum_q [vna_dsp_params_pkg::NUM_CH];
    logic signed [vna_dsp_params_pkg::ACC_W-1:0] mean_i [vna_dsp_params_pkg::NUM_CH];
    logic signed [vna_dsp_params_pkg::ACC_W-1:0] mean_q [vna_dsp_params_pkg::NUM_CH];
    logic                                        in_valid;
    logic                                        in_last;
    logic [vna_dsp_params_pkg::LOG2_W-1:0]       shift;

    // Channel 0 marks the frame for all four
    assign in_valid = in[0].valid;
    assign in_last  = in[0].last;
    assign shift    = in[0].frame_log2;

    for (genvar k = 0; k < vna_dsp_params_pkg::NUM_CH; k++) begin : g_ch
        assign smp_i[k]  = in[k].sample.i;
        assign smp_q[k]  = in[k].sample.q;
        assign sum_i[k]  = acc_i[k] + vna_dsp_params_pkg::ACC_W'(smp_i[k]);
        assign sum_q[k]  = acc_q[k] + vna_dsp_params_pkg::ACC_W'(smp_q[k]);
        assign mean_i[k] = sum_i[k] >>> shift;  // Mean is a shift for 2^n samples
        assign mean_q[k] = sum_q[k] >>> shift;
    end

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            avg_valid <= 1'b0;
            avg_i     <= '0;
            avg_q     <= '0;
            for (int k = 0; k < vna_dsp_params_pkg::NUM_CH; k++) begin
                acc_i[k] <= '0;
                acc_q[k] <= '0;
            end
        end else begin
            avg_valid <= in_valid && in_last;
            if (in_valid) begin
                for (int k = 0; k < vna_dsp_params_pkg::NUM_CH; k++) begin
                    if (in_last) begin
                        // Truncate and start over for the next frame
                        avg_i[k] <= mean_i[k][vna_dsp_params_pkg::SAMPLE_W-1:0];
                        avg_q[k] <= mean_q[k][vna_dsp_params_pkg::SAMPLE_W-1:0];
                        acc_i[k] <= '0;
                        acc_q[k] <= '0;
                    end else begin
                        acc_i[k] <= sum_i[k];
                        acc_q[k] <= sum_q[k];
                    end
                end
            end
        end
    end

endmodule

// File: hw/rx_channel_filter.sv
`timescale 1ns/1ps

module rx_channel_filter (
    input  logic     aclk,
    input  logic     rst_n,
    iq_stream_if.dst in,
    iq_stream_if.src out
);

    vna_dsp_types_pkg::iq_t                        taps [vna_dsp_params_pkg::NUM_TAPS];
    logic signed [vna_dsp_params_pkg::FIR_ACC_W-1:0] sum_i;
    logic signed [vna_dsp_params_pkg::FIR_ACC_W-1:0] sum_q;
    logic                                          valid_q;
    logic                                          last_q;
    logic [vna_dsp_params_pkg::LOG2_W-1:0]         log2_q;

    // Scale back by the coefficient fraction and clip to the sample range
    function automatic vna_dsp_types_pkg::sample_t sat_scale(
        input logic signed [vna_dsp_params_pkg::FIR_ACC_W-1:0] v
    );
        logic signed [vna_dsp_params_pkg::FIR_ACC_W-1:0] s;
        s = v >>> vna_dsp_params_pkg::COEF_FRAC;
        if (s > vna_dsp_params_pkg::FIR_ACC_W'(2 ** (vna_dsp_params_pkg::SAMPLE_W - 1) - 1)) begin
            return {1'b0, {(vna_dsp_params_pkg::SAMPLE_W - 1){1'b1}}};
        end else if (s < vna_dsp_params_pkg::FIR_ACC_W'(
                             -(2 ** (vna_dsp_params_pkg::SAMPLE_W - 1)))) begin
            return {1'b1, {(vna_dsp_params_pkg::SAMPLE_W - 1){1'b0}}};
        end
        return s[vna_dsp_params_pkg::SAMPLE_W-1:0];
    endfunction

    // Tap 0 holds the newest sample
    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            for (int n = 0; n < vna_dsp_params_pkg::NUM_TAPS; n++) begin
                taps[n] <= '0;
            end
        end else if (in.valid) begin
            taps[0] <= in.sample;
            for (int n = 1; n < vna_dsp_params_pkg::NUM_TAPS; n++) begin
                taps[n] <= taps[n-1];
            end
        end
    end

    // Frame marking follows the data by one cycle
    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
            last_q  <= 1'b0;
            log2_q  <= '0;
        end else begin
            valid_q <= in.valid;
            last_q  <= in.valid && in.last;
            log2_q  <= in.frame_log2;
        end
    end

    always_comb begin
        sum_i = '0;
        sum_q = '0;
        for (int n = 0; n < vna_dsp_params_pkg::NUM_TAPS; n++) begin
            sum_i = sum_i + taps[n].i * vna_dsp_params_pkg::FIR_COEFS[n];
            sum_q = sum_q + taps[n].q * vna_dsp_params_pkg::FIR_COEFS[n];
        end
    end

    assign out.valid      = valid_q;
    assign out.last       = last_q;
    assign out.frame_log2 = log2_q;
    assign out.sample.i   = sat_scale(sum_i);
    assign out.sample.q   = sat_scale(sum_q);

endmodule

// File: hw/frame_sequencer.sv
`timescale 1ns/1ps

module frame_sequencer (
    input  logic                                    aclk,
    input  logic                                    rst_n,
    input  logic                                    start,
    input  logic [vna_dsp_params_pkg::LOG2_W-1:0]   frame_log2,
    input  logic                                    adc_valid,
    input  logic [vna_dsp_params_pkg::NUM_CH-1:0]
                 [vna_dsp_params_pkg::ADC_W-1:0]    adc_data,
    output logic                                    busy,
    iq_stream_if.src                                out [vna_dsp_params_pkg::NUM_CH]
);

    vna_dsp_types_pkg::seq_state_e          state;
    logic [vna_dsp_params_pkg::LOG2_W-1:0]  log2_q;
    logic [vna_dsp_params_pkg::LOG2_W-1:0]  log2_clamped;
    logic [vna_dsp_params_pkg::CNT_W-1:0]   cnt;
    logic [vna_dsp_params_pkg::CNT_W-1:0]   last_idx;
    logic                                   take;
    logic                                   frame_end;
    logic                                   vld_q;
    logic                                   last_q;
    vna_dsp_types_pkg::iq_t                 data_q [vna_dsp_params_pkg::NUM_CH];

    assign log2_clamped = (frame_log2 > vna_dsp_params_pkg::LOG2_W'(
                              vna_dsp_params_pkg::MAX_FRAME_LOG2)) ?
                          vna_dsp_params_pkg::LOG2_W'(vna_dsp_params_pkg::MAX_FRAME_LOG2) :
                          frame_log2;

    // Index of the final sample, 2^n - 1
    assign last_idx  = (vna_dsp_params_pkg::CNT_W'(1) << log2_q) -
                       vna_dsp_params_pkg::CNT_W'(1);
    assign take      = (state == vna_dsp_types_pkg::SEQ_RUN) && adc_valid;
    assign frame_end = (cnt == last_idx);
    assign busy      = (state == vna_dsp_types_pkg::SEQ_RUN);

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            state  <= vna_dsp_types_pkg::SEQ_IDLE;
            log2_q <= '0;
            cnt    <= '0;
            vld_q  <= 1'b0;
            last_q <= 1'b0;
        end else begin
            vld_q  <= take;
            last_q <= take && frame_end;
            case (state)
                vna_dsp_types_pkg::SEQ_IDLE: begin
                    if (start) begin  // adc_valid in this cycle is dropped
                        log2_q <= log2_clamped;
                        cnt    <= '0;
                        state  <= vna_dsp_types_pkg::SEQ_RUN;
                    end
                end
                vna_dsp_types_pkg::SEQ_RUN: begin
                    if (adc_valid) begin
                        cnt <= cnt + vna_dsp_params_pkg::CNT_W'(1);
                        if (frame_end) begin
                            state <= vna_dsp_types_pkg::SEQ_IDLE;
                        end
                    end
                end
                default: state <= vna_dsp_types_pkg::SEQ_IDLE;
            endcase
        end
    end

    // Split each gated word into I and Q
    always_ff @(posedge aclk) begin
        if (take) begin
            for (int k = 0; k < vna_dsp_params_pkg::NUM_CH; k++) begin
                data_q[k].i <= adc_data[k][vna_dsp_params_pkg::ADC_W-1:
                                           vna_dsp_params_pkg::SAMPLE_W];
                data_q[k].q <= adc_data[k][vna_dsp_params_pkg::SAMPLE_W-1:0];
            end
        end
    end

    // All channels move in lockstep
    for (genvar k = 0; k < vna_dsp_params_pkg::NUM_CH; k++) begin : g_out
        assign out[k].valid      = vld_q;
        assign out[k].last       = last_q;
        assign out[k].sample     = data_q[k];
        assign out[k].frame_log2 = log2_q;
    end

endmodule

// File: hw/iq_stream_if.sv
`timescale 1ns/1ps

// One complex sample stream, no back-pressure
interface iq_stream_if (
    input logic aclk
);
    logic                                  valid;
    logic                                  last;        // Final sample of the frame
    vna_dsp_types_pkg::iq_t                sample;
    logic [vna_dsp_params_pkg::LOG2_W-1:0] frame_log2;  // Exponent latched at frame start

    modport src (
        input  aclk,
        output valid,
        output last,
        output sample,
        output frame_log2
    );

    modport dst (
        input aclk,
        input valid,
        input last,
        input sample,
        input frame_log2
    );

endinterface

// File: hw/vna_dsp_types_pkg.sv
package vna_dsp_types_pkg;

    typedef logic signed [vna_dsp_params_pkg::SAMPLE_W-1:0] sample_t;

    // Same bit order as the ADC word
    typedef struct packed {
        sample_t i;
        sample_t q;
    } iq_t;

    typedef enum logic {
        SEQ_IDLE = 1'b0,
        SEQ_RUN  = 1'b1
    } seq_state_e;

endpackage

// File: hw/vna_dsp_params_pkg.sv
package vna_dsp_params_pkg;

    // Receiver channels: p1 reverse, p1 forward, p2 reverse, p2 forward
    localparam int NUM_CH = 4;

    localparam int ADC_W    = 32;  // I in upper half, Q in lower half
    localparam int SAMPLE_W = 16;

    // Low-pass FIR, symmetric, unity DC gain after the shift
    localparam int NUM_TAPS  = 8;
    localparam int COEF_FRAC = 15;
    localparam logic signed [SAMPLE_W-1:0] FIR_COEFS [NUM_TAPS] = '{
        16'sd512, 16'sd2048, 16'sd5120, 16'sd8704,
        16'sd8704, 16'sd5120, 16'sd2048, 16'sd512
    };

    // Product width plus growth for eight terms
    localparam int FIR_ACC_W = 2 * SAMPLE_W + 3;

    localparam int ACC_W = 32;

    // Frame length is 2^frame_log2 samples
    localparam int MAX_FRAME_LOG2 = 8;
    localparam int LOG2_W         = 4;
    localparam int CNT_W          = MAX_FRAME_LOG2 + 1;

endpackage
